// ==== include/maxpool_params.svh ====
`ifndef MAXPOOL_PARAMS_SVH
`define MAXPOOL_PARAMS_SVH

// Number of channel groups per beat.
`define MP_GROUPS 2

// Number of units in each group.
`define MP_UNITS 3

// Width of one signed pixel word.
`define MP_WORD_WIDTH 8

// Output beats per tlast.
`define MP_MEMBERS 8

// Both copies of the grid, in words.
`define MP_COPIES 2

`endif

// ==== design/maxpool_pkg.sv ====
`default_nettype none

`include "maxpool_params.svh"

package maxpool_pkg;

  // One signed pixel.
  typedef logic signed [`MP_WORD_WIDTH-1:0] word_t;

  // Indexed as [copy][group][unit].
  typedef word_t [`MP_COPIES-1:0][`MP_GROUPS-1:0][`MP_UNITS-1:0] grid_t;

  // One keep bit per word, same order as grid_t.
  typedef logic [`MP_COPIES-1:0][`MP_GROUPS-1:0][`MP_UNITS-1:0] keep_t;

  typedef struct packed {
    grid_t grid;
    logic  is_max;
  } in_beat_t;

  typedef struct packed {
    grid_t grid;
    keep_t keep;
    logic  last;
  } out_beat_t;

  // Signed maximum of two words.
  function automatic word_t word_max(input word_t a, input word_t b);
    return (a > b) ? a : b;
  endfunction

endpackage

`default_nettype wire

// ==== design/axis_register_slice.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_register_slice #(
  parameter type payload_t = logic
) (
  input  logic     aclk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  logic     main_valid;
  logic     main_valid_d;
  payload_t main_data;
  logic     skid_valid;
  logic     skid_valid_d;
  payload_t skid_data;
  logic     in_accept;
  logic     main_load;

  assign in_accept = in_valid & in_ready;
  // Main register is free when empty or being drained this cycle.
  assign main_load = out_ready | ~main_valid;

  always_comb begin
    main_valid_d = main_valid;
    skid_valid_d = skid_valid;
    if (main_load) begin
      main_valid_d = skid_valid | in_accept;
      skid_valid_d = 1'b0;
    end else if (in_accept) begin
      skid_valid_d = 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
      main_data  <= '0;
    end else begin
      main_valid <= main_valid_d;
      skid_valid <= skid_valid_d;
      // Ready is registered, low only while the spare entry is occupied.
      in_ready   <= ~skid_valid_d;
      if (main_load && (skid_valid || in_accept)) begin
        main_data <= skid_valid ? skid_data : in_data;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (in_accept && !main_load) begin
      skid_data <= in_data;
    end
  end

  assign out_valid = main_valid;
  assign out_data  = main_data;

endmodule

`default_nettype wire

// ==== design/maxpool_lane_max.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "maxpool_params.svh"

module maxpool_lane_max (
  input  logic                  aclk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  maxpool_pkg::in_beat_t in_data,
  output logic                  in_ready,
  output logic                  out_valid,
  output maxpool_pkg::in_beat_t out_data,
  input  logic                  out_ready
);

  maxpool_pkg::in_beat_t reduced;
  logic                  in_accept;

  // Horizontal half of the 2x2 window, copy 0 against copy 1.
  always_comb begin
    reduced = in_data;
    if (in_data.is_max) begin
      for (int g = 0; g < `MP_GROUPS; g++) begin
        for (int u = 0; u < `MP_UNITS; u++) begin
          reduced.grid[0][g][u] = maxpool_pkg::word_max(in_data.grid[0][g][u],
                                                        in_data.grid[1][g][u]);
        end
      end
    end
  end

  // Stage register takes a beat whenever it is empty or being drained.
  assign in_ready  = out_ready | ~out_valid;
  assign in_accept = in_valid & in_ready;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (in_accept) begin
      out_data <= reduced;
    end
  end

endmodule

`default_nettype wire

// ==== design/maxpool_window_accum.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "maxpool_params.svh"

module maxpool_window_accum (
  input  logic                   aclk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  maxpool_pkg::in_beat_t  in_data,
  output logic                   in_ready,
  output logic                   out_valid,
  output maxpool_pkg::out_beat_t out_data,
  input  logic                   out_ready
);

  localparam int CNT_W = ($clog2(`MP_MEMBERS) > 0) ? $clog2(`MP_MEMBERS) : 1;

  logic                   half;
  logic [CNT_W-1:0]       out_count;
  logic                   count_wrap;
  logic                   in_accept;
  logic                   emit;
  maxpool_pkg::grid_t     held;
  maxpool_pkg::grid_t     pooled;
  maxpool_pkg::keep_t     pool_keep;
  maxpool_pkg::out_beat_t next_beat;

  assign in_ready   = out_ready | ~out_valid;
  assign in_accept  = in_valid & in_ready;
  // A first pooling beat is only held, everything else produces a beat.
  assign emit       = in_accept & (~in_data.is_max | half);
  assign count_wrap = (out_count == CNT_W'(`MP_MEMBERS - 1));

  // Vertical half of the window, copy 1 is zeroed and masked.
  always_comb begin
    pooled    = '0;
    pool_keep = '0;
    for (int g = 0; g < `MP_GROUPS; g++) begin
      for (int u = 0; u < `MP_UNITS; u++) begin
        pooled[0][g][u]    = maxpool_pkg::word_max(held[0][g][u], in_data.grid[0][g][u]);
        pool_keep[0][g][u] = 1'b1;
      end
    end
  end

  always_comb begin
    next_beat.last = count_wrap;
    if (in_data.is_max) begin
      next_beat.grid = pooled;
      next_beat.keep = pool_keep;
    end else begin
      next_beat.grid = in_data.grid;
      next_beat.keep = '1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      half      <= 1'b0;
      out_count <= '0;
    end else begin
      if (out_ready) begin
        out_valid <= 1'b0;
      end
      if (emit) begin
        out_valid <= 1'b1;
        out_count <= count_wrap ? '0 : out_count + 1'b1;
      end
      if (in_accept && in_data.is_max) begin
        half <= ~half;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (in_accept && in_data.is_max && !half) begin
      held <= in_data.grid;
    end
    if (emit) begin
      out_data <= next_beat;
    end
  end

endmodule

`default_nettype wire

// ==== design/axis_maxpool_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_maxpool_engine (
  input  logic               aclk,
  input  logic               rst_n,
  input  logic               s_axis_tvalid,
  output logic               s_axis_tready,
  input  maxpool_pkg::grid_t s_axis_tdata,
  input  logic               s_axis_tuser,
  output logic               m_axis_tvalid,
  input  logic               m_axis_tready,
  output maxpool_pkg::grid_t m_axis_tdata,
  output maxpool_pkg::keep_t m_axis_tkeep,
  output logic               m_axis_tlast
);

  maxpool_pkg::in_beat_t  s_beat;
  maxpool_pkg::in_beat_t  slice_data;
  logic                   slice_valid;
  logic                   slice_ready;
  maxpool_pkg::in_beat_t  lane_data;
  logic                   lane_valid;
  logic                   lane_ready;
  maxpool_pkg::out_beat_t accum_data;
  logic                   accum_valid;
  logic                   accum_ready;
  maxpool_pkg::out_beat_t m_beat;

  assign s_beat.grid   = s_axis_tdata;
  assign s_beat.is_max = s_axis_tuser;

  axis_register_slice #(
    .payload_t (maxpool_pkg::in_beat_t)
  ) i_in_slice (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (s_axis_tvalid),
    .in_data   (s_beat),
    .in_ready  (s_axis_tready),
    .out_valid (slice_valid),
    .out_data  (slice_data),
    .out_ready (slice_ready)
  );

  maxpool_lane_max i_lane_max (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (slice_valid),
    .in_data   (slice_data),
    .in_ready  (slice_ready),
    .out_valid (lane_valid),
    .out_data  (lane_data),
    .out_ready (lane_ready)
  );

  maxpool_window_accum i_window_accum (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (lane_valid),
    .in_data   (lane_data),
    .in_ready  (lane_ready),
    .out_valid (accum_valid),
    .out_data  (accum_data),
    .out_ready (accum_ready)
  );

  axis_register_slice #(
    .payload_t (maxpool_pkg::out_beat_t)
  ) i_out_slice (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (accum_valid),
    .in_data   (accum_data),
    .in_ready  (accum_ready),
    .out_valid (m_axis_tvalid),
    .out_data  (m_beat),
    .out_ready (m_axis_tready)
  );

  assign m_axis_tdata = m_beat.grid;
  assign m_axis_tkeep = m_beat.keep;
  assign m_axis_tlast = m_beat.last;

endmodule

`default_nettype wire

// ==== verification/axis_maxpool_engine_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_maxpool_engine_checker (
  input logic                   aclk,
  input logic                   rst_n,
  input logic                   s_axis_tvalid,
  input logic                   s_axis_tready,
  input maxpool_pkg::grid_t     s_axis_tdata,
  input logic                   s_axis_tuser,
  input logic                   m_axis_tvalid,
  input logic                   m_axis_tready,
  input maxpool_pkg::grid_t     m_axis_tdata,
  input maxpool_pkg::keep_t     m_axis_tkeep,
  input logic                   m_axis_tlast,
  input logic                   lane_valid,
  input logic                   lane_ready,
  input maxpool_pkg::in_beat_t  lane_data,
  input maxpool_pkg::out_beat_t accum_data
);

  int assert_errors;

  initial assert_errors = 0;

  // A stalled input beat must be held until accepted.
  s_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    s_axis_tvalid && !s_axis_tready |=>
      s_axis_tvalid && $stable(s_axis_tdata) && $stable(s_axis_tuser))
    else begin
      $error("input beat changed or dropped while stalled");
      assert_errors++;
    end

  m_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tkeep) && $stable(m_axis_tlast))
    else begin
      $error("output beat changed or dropped while stalled");
      assert_errors++;
    end

  // Outputs are quiet in the cycle after a reset edge.
  reset_quiet: assert property (@(posedge aclk)
    !rst_n |=> !m_axis_tvalid && !m_axis_tlast && !s_axis_tready)
    else begin
      $error("stream outputs active right after reset");
      assert_errors++;
    end

  bypass_keep: assert property (@(posedge aclk) disable iff (!rst_n)
    lane_valid && lane_ready && !lane_data.is_max |=> accum_data.keep == '1)
    else begin
      $error("bypass beat emitted without full keep");
      assert_errors++;
    end

endmodule

`default_nettype wire

// ==== verification/axis_maxpool_engine_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "maxpool_params.svh"

module axis_maxpool_engine_tb;

  localparam int RESET_CYCLES   = 16;
  localparam int N_BYPASS       = 12;
  localparam int N_POOL_PAIRS   = 8;
  localparam int N_MIXED_GROUPS = 4;
  localparam int N_RANDOM       = 80;
  localparam int N_RESET_PRE    = 3;
  localparam int N_RESET_POST   = 10;
  // The random phase may add one beat to close a pending pair.
  localparam int NUM_BEATS = N_BYPASS + 2 * N_POOL_PAIRS + 4 * N_MIXED_GROUPS
                           + N_RANDOM + 1 + N_RESET_PRE + N_RESET_POST;
  localparam int TIMEOUT     = 2 * NUM_BEATS + 200;
  localparam int DRAIN_LIMIT = 64;

  localparam maxpool_pkg::word_t WORD_MIN = {1'b1, {(`MP_WORD_WIDTH-1){1'b0}}};
  localparam maxpool_pkg::word_t WORD_MAX = {1'b0, {(`MP_WORD_WIDTH-1){1'b1}}};

  logic               aclk;
  logic               rst_n;
  logic               s_axis_tvalid;
  logic               s_axis_tready;
  maxpool_pkg::grid_t s_axis_tdata;
  logic               s_axis_tuser;
  logic               m_axis_tvalid;
  logic               m_axis_tready;
  maxpool_pkg::grid_t m_axis_tdata;
  maxpool_pkg::keep_t m_axis_tkeep;
  logic               m_axis_tlast;

  integer                 seed;
  int                     error_count;
  int                     out_count;
  int                     cycle_count;
  int                     exp_count;
  int                     fill_base;
  logic                   ref_half;
  maxpool_pkg::grid_t     ref_held;
  logic                   ready_random;
  logic                   ready_level;
  maxpool_pkg::out_beat_t exp_q[$];

  axis_maxpool_engine i_dut (
    .aclk          (aclk),
    .rst_n         (rst_n),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tuser  (s_axis_tuser),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tkeep  (m_axis_tkeep),
    .m_axis_tlast  (m_axis_tlast)
  );

  bind axis_maxpool_engine axis_maxpool_engine_checker i_checker (
    .aclk          (aclk),
    .rst_n         (rst_n),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tuser  (s_axis_tuser),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tkeep  (m_axis_tkeep),
    .m_axis_tlast  (m_axis_tlast),
    .lane_valid    (lane_valid),
    .lane_ready    (lane_ready),
    .lane_data     (lane_data),
    .accum_data    (accum_data)
  );

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  // Expected output for one bypass beat or one pooling pair.
  function automatic maxpool_pkg::out_beat_t reference_beat(input maxpool_pkg::grid_t first,
                                                            input maxpool_pkg::grid_t second,
                                                            input logic pooled);
    maxpool_pkg::out_beat_t beat;
    maxpool_pkg::word_t     m;
    beat = '0;
    if (!pooled) begin
      beat.grid = first;
      beat.keep = '1;
    end else begin
      for (int g = 0; g < `MP_GROUPS; g++) begin
        for (int u = 0; u < `MP_UNITS; u++) begin
          m = first[0][g][u];
          if (first[1][g][u] > m) m = first[1][g][u];
          if (second[0][g][u] > m) m = second[0][g][u];
          if (second[1][g][u] > m) m = second[1][g][u];
          beat.grid[0][g][u] = m;
          beat.keep[0][g][u] = 1'b1;
        end
      end
    end
    return beat;
  endfunction

  function automatic maxpool_pkg::grid_t fill_grid(input int base);
    maxpool_pkg::grid_t grid;
    int                 idx;
    idx = 0;
    for (int c = 0; c < `MP_COPIES; c++) begin
      for (int g = 0; g < `MP_GROUPS; g++) begin
        for (int u = 0; u < `MP_UNITS; u++) begin
          grid[c][g][u] = maxpool_pkg::word_t'(base + idx);
          idx++;
        end
      end
    end
    return grid;
  endfunction

  function automatic maxpool_pkg::grid_t const_grid(input maxpool_pkg::word_t w);
    maxpool_pkg::grid_t grid;
    for (int c = 0; c < `MP_COPIES; c++) begin
      for (int g = 0; g < `MP_GROUPS; g++) begin
        for (int u = 0; u < `MP_UNITS; u++) begin
          grid[c][g][u] = w;
        end
      end
    end
    return grid;
  endfunction

  function automatic maxpool_pkg::grid_t random_grid(input logic negative);
    maxpool_pkg::grid_t grid;
    for (int c = 0; c < `MP_COPIES; c++) begin
      for (int g = 0; g < `MP_GROUPS; g++) begin
        for (int u = 0; u < `MP_UNITS; u++) begin
          grid[c][g][u] = maxpool_pkg::word_t'($random(seed));
          if (negative) grid[c][g][u][`MP_WORD_WIDTH-1] = 1'b1;
        end
      end
    end
    return grid;
  endfunction

  task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("error at %0t ns: %s mismatch, got %h expected %h",
               $time, what, actual, expected);
      error_count++;
    end
  endtask

  task automatic push_expected(input maxpool_pkg::out_beat_t beat);
    maxpool_pkg::out_beat_t b;
    b      = beat;
    b.last = (exp_count == `MP_MEMBERS - 1);
    exp_count = (exp_count + 1) % `MP_MEMBERS;
    exp_q.push_back(b);
  endtask

  // A bypass beat never disturbs a pending pair.
  task automatic model_beat(input maxpool_pkg::grid_t grid, input logic is_max);
    if (!is_max) begin
      push_expected(reference_beat(grid, grid, 1'b0));
    end else if (!ref_half) begin
      ref_held = grid;
      ref_half = 1'b1;
    end else begin
      push_expected(reference_beat(ref_held, grid, 1'b1));
      ref_half = 1'b0;
    end
  endtask

  // Starts and returns a small delay after a rising edge.
  task automatic send_beat(input maxpool_pkg::grid_t grid, input logic is_max, input int idle);
    logic accepted;
    model_beat(grid, is_max);
    s_axis_tvalid = 1'b0;
    repeat (idle) begin
      @(posedge aclk);
      #1;
    end
    s_axis_tvalid = 1'b1;
    s_axis_tdata  = grid;
    s_axis_tuser  = is_max;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge aclk);
      accepted = s_axis_tready;
      @(posedge aclk);
      #1;
    end
    s_axis_tvalid = 1'b0;
  endtask

  task automatic send_fill();
    send_beat(fill_grid(fill_base), 1'b0, 0);
    fill_base = fill_base + `MP_COPIES * `MP_GROUPS * `MP_UNITS;
  endtask

  task automatic apply_reset();
    rst_n         = 1'b0;
    s_axis_tvalid = 1'b0;
    exp_q.delete();
    ref_half  = 1'b0;
    exp_count = 0;
    repeat (RESET_CYCLES) @(posedge aclk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge aclk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Output stream stalled with %0d expected beats never delivered", exp_q.size());
      error_count++;
      exp_q.delete();
    end
    repeat (4) @(posedge aclk);
    #1;
  endtask

  // Output ready is random in the stall phase and a fixed level otherwise.
  initial begin
    logic [31:0] draw;
    forever begin
      @(posedge aclk);
      draw = $random(seed);
      #1;
      m_axis_tready = ready_random ? (draw[1:0] != 2'b00) : ready_level;
    end
  end

  initial begin
    maxpool_pkg::out_beat_t expected;
    forever begin
      @(negedge aclk);
      if (rst_n && m_axis_tvalid && m_axis_tready) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected output beat at %0t ns while nothing was expected", $time);
          error_count++;
        end else begin
          expected = exp_q.pop_front();
          check_value(m_axis_tdata, expected.grid, "tdata");
          check_value(m_axis_tkeep, expected.keep, "tkeep");
          check_value(m_axis_tlast, expected.last, "tlast");
          out_count++;
        end
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT) begin
      @(posedge aclk);
      cycle_count++;
    end
    $display("Run stopped by timeout after %0d cycles with %0d errors", cycle_count, error_count);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [31:0]        r;
    maxpool_pkg::grid_t a;
    maxpool_pkg::grid_t b;
    seed          = 32'h0ef1439c;
    error_count   = 0;
    out_count     = 0;
    exp_count     = 0;
    fill_base     = 0;
    ref_half      = 1'b0;
    ref_held      = '0;
    ready_random  = 1'b0;
    ready_level   = 1'b1;
    rst_n         = 1'b0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tuser  = 1'b0;
    m_axis_tready = 1'b1;
    apply_reset();

    for (int i = 0; i < N_BYPASS; i++) send_fill();
    wait_for_drain();

    // Word limits first, then negative and fully random pairs.
    for (int p = 0; p < N_POOL_PAIRS; p++) begin
      case (p)
        0: begin
          a = const_grid(WORD_MIN);
          b = const_grid(WORD_MIN);
        end
        1: begin
          a = const_grid(WORD_MIN);
          b = const_grid(WORD_MAX);
        end
        2: begin
          a = const_grid(WORD_MIN);
          b = const_grid('1);
        end
        3, 4: begin
          a = random_grid(1'b1);
          b = random_grid(1'b1);
        end
        default: begin
          a = random_grid(1'b0);
          b = random_grid(1'b0);
        end
      endcase
      send_beat(a, 1'b1, 0);
      send_beat(b, 1'b1, 0);
    end
    wait_for_drain();

    for (int k = 0; k < N_MIXED_GROUPS; k++) begin
      send_beat(random_grid(1'b0), 1'b1, 0);
      send_fill();
      send_fill();
      send_beat(random_grid(1'b0), 1'b1, 0);
    end
    wait_for_drain();

    ready_random = 1'b1;
    for (int i = 0; i < N_RANDOM; i++) begin
      r = $random(seed);
      send_beat(random_grid(1'b0), r[0], (r[3:2] == 2'b00) ? 1 : 0);
    end
    if (ref_half) send_beat(random_grid(1'b0), 1'b1, 0);
    ready_random = 1'b0;
    ready_level  = 1'b1;
    wait_for_drain();

    // Leave beats in flight and half a pair pending before the reset.
    ready_level = 1'b0;
    @(posedge aclk);
    #1;
    send_fill();
    send_beat(random_grid(1'b0), 1'b1, 0);
    send_fill();
    // The first pooling beat has to reach the accumulator.
    repeat (4) @(posedge aclk);
    #1;
    apply_reset();
    ready_level = 1'b1;
    repeat (8) @(posedge aclk);
    #1;
    send_beat(random_grid(1'b1), 1'b1, 0);
    send_beat(random_grid(1'b0), 1'b1, 0);
    for (int i = 0; i < N_RESET_POST - 2; i++) send_fill();
    wait_for_drain();

    $display("Checked %0d output beats: %0d errors, %0d assertion failures",
             out_count, error_count, i_dut.i_checker.assert_errors);
    if (error_count == 0 && i_dut.i_checker.assert_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
design/maxpool_pkg.sv
design/axis_register_slice.sv
design/maxpool_lane_max.sv
design/maxpool_window_accum.sv
design/axis_maxpool_engine.sv
verification/axis_maxpool_engine_checker.sv
verification/axis_maxpool_engine_tb.sv

// ==== Bender.yml ====
package:
  name: axis_maxpool_engine

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/maxpool_pkg.sv
      - design/axis_register_slice.sv
      - design/maxpool_lane_max.sv
      - design/maxpool_window_accum.sv
      - design/axis_maxpool_engine.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/axis_maxpool_engine_checker.sv
      - verification/axis_maxpool_engine_tb.sv
